// File: verilog.f
cpu_pkg.sv
pipe_if.sv
regfile.sv
alu.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
core_top.sv
tb_core.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_core -f verilog.f

run: compile
	@out="$$(./obj_dir/Vtb_core)"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core import cpu_pkg::*; ();

    logic       clk;
    logic       resetn;
    logic       inst_valid;
    word_t      inst;
    logic       inst_allowin;
    logic       data_sram_en;
    logic [3:0] data_sram_we;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    logic       wb_valid;
    reg_idx_t   wb_rf_waddr;
    word_t      wb_rf_wdata;

    word_t      sram [0:255];
    word_t      ref_mem [0:255];
    word_t      ref_rf [0:31];
    word_t      prog [$];
    reg_idx_t   exp_waddr [$];
    word_t      exp_wdata [$];
    logic       acc_store [$];
    word_t      acc_addr [$];
    word_t      acc_data [$];
    int         seed = 32'h562c_79d3;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         stall_count = 0;

    core_top i_core_top (
        .clk(clk), .resetn(resetn),
        .inst_valid(inst_valid), .inst(inst), .inst_allowin(inst_allowin),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata),
        .wb_valid(wb_valid), .wb_rf_waddr(wb_rf_waddr), .wb_rf_wdata(wb_rf_wdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            fail_run();
        end
    endtask

    // Every word differs and depends on all address bits
    function automatic word_t fill_word(int i);
        word_t a;
        a = word_t'(i);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic word_t asm_3r(logic [16:0] op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t asm_ri12(logic [9:0] op, reg_idx_t rd, reg_idx_t rj,
                                       logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic word_t asm_lu12i(reg_idx_t rd, logic [19:0] imm);
        return {OP_LU12I_W, imm, rd};
    endfunction

    function automatic logic is_three_reg(word_t w);
        return w[31:15] == OP_ADD_W || w[31:15] == OP_SUB_W || w[31:15] == OP_SLT
            || w[31:15] == OP_SLTU  || w[31:15] == OP_NOR   || w[31:15] == OP_AND
            || w[31:15] == OP_OR    || w[31:15] == OP_XOR;
    endfunction

    // Source registers as the ISA defines them
    function automatic logic reads_reg(word_t w, reg_idx_t r);
        if (w[31:25] == OP_LU12I_W) begin
            return 1'b0;
        end
        if (w[31:22] == OP_ST_W) begin
            return w[9:5] == r || w[4:0] == r;
        end
        if (is_three_reg(w)) begin
            return w[9:5] == r || w[14:10] == r;
        end
        return w[9:5] == r;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    task automatic run_model(word_t w);
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    d;
        word_t    si12;
        word_t    addr;
        word_t    res;
        logic     wr;
        rd   = w[4:0];
        a    = ref_rf[w[9:5]];
        b    = ref_rf[w[14:10]];
        d    = ref_rf[w[4:0]];
        si12 = {{20{w[21]}}, w[21:10]};
        addr = a + si12;
        res  = WORD_ZERO;
        wr   = 1'b1;
        if (w[31:15] == OP_ADD_W) res = a + b;
        else if (w[31:15] == OP_SUB_W) res = a - b;
        else if (w[31:15] == OP_SLT) res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        else if (w[31:15] == OP_SLTU) res = (a < b) ? 32'd1 : 32'd0;
        else if (w[31:15] == OP_NOR) res = ~(a | b);
        else if (w[31:15] == OP_AND) res = a & b;
        else if (w[31:15] == OP_OR) res = a | b;
        else if (w[31:15] == OP_XOR) res = a ^ b;
        else if (w[31:15] == OP_SLLI_W) res = a << w[14:10];
        else if (w[31:15] == OP_SRLI_W) res = a >> w[14:10];
        else if (w[31:15] == OP_SRAI_W) res = $signed(a) >>> w[14:10];
        else if (w[31:22] == OP_ADDI_W) res = a + si12;
        else if (w[31:25] == OP_LU12I_W) res = {w[24:5], 12'h000};
        else if (w[31:22] == OP_LD_W) begin
            res = ref_mem[addr[9:2]];
            acc_store.push_back(1'b0);
            acc_addr.push_back(addr);
            acc_data.push_back(WORD_ZERO);
        end else if (w[31:22] == OP_ST_W) begin
            ref_mem[addr[9:2]] = d;
            wr = 1'b0;
            acc_store.push_back(1'b1);
            acc_addr.push_back(addr);
            acc_data.push_back(d);
        end else begin
            $display("Program holds an unsupported instruction word %h", w);
            fail_run();
        end
        // r0 never changes
        if (wr && rd != REG_ZERO) begin
            ref_rf[rd] = res;
            exp_waddr.push_back(rd);
            exp_wdata.push_back(res);
        end
    endtask

    ////////////////////////////////////////
    // Program
    ////////////////////////////////////////
    task automatic add_random_inst();
        word_t    r;
        word_t    w;
        int       kind;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        r    = $random(seed);
        rd   = {2'b00, r[2:0]};
        rj   = {2'b00, r[5:3]};
        rk   = {2'b00, r[8:6]};
        kind = int'(r[31:28]) % 15;
        case (kind)
            0:  w = asm_3r(OP_ADD_W, rd, rj, rk);
            1:  w = asm_3r(OP_SUB_W, rd, rj, rk);
            2:  w = asm_3r(OP_SLT, rd, rj, rk);
            3:  w = asm_3r(OP_SLTU, rd, rj, rk);
            4:  w = asm_3r(OP_AND, rd, rj, rk);
            5:  w = asm_3r(OP_OR, rd, rj, rk);
            6:  w = asm_3r(OP_NOR, rd, rj, rk);
            7:  w = asm_3r(OP_XOR, rd, rj, rk);
            8:  w = asm_3r(OP_SLLI_W, rd, rj, r[13:9]);
            9:  w = asm_3r(OP_SRLI_W, rd, rj, r[13:9]);
            10: w = asm_3r(OP_SRAI_W, rd, rj, r[13:9]);
            11: w = asm_ri12(OP_ADDI_W, rd, rj, r[27:16]);
            12: w = asm_lu12i(rd, r[28:9]);
            // Word addresses inside the SRAM with r0 as base
            13: w = asm_ri12(OP_LD_W, rd, 5'd0, {2'b00, r[17:10], 2'b00});
            default: w = asm_ri12(OP_ST_W, rd, 5'd0, {2'b00, r[17:10], 2'b00});
        endcase
        prog.push_back(w);
    endtask

    task automatic build_program();
        // Register setup where r3 and r4 also need bypass from execute
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd1, 5'd0, 12'h005));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd2, 5'd0, 12'hffd));
        prog.push_back(asm_lu12i(5'd3, 20'h80000));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd3, 5'd3, 12'h001));
        prog.push_back(asm_lu12i(5'd4, 20'h12345));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd4, 5'd4, 12'h678));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd5, 5'd0, 12'h7ff));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd6, 5'd0, 12'h800));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd7, 5'd0, 12'h040));
        // Register-register ALU ops
        prog.push_back(asm_3r(OP_ADD_W, 5'd8, 5'd1, 5'd2));
        prog.push_back(asm_3r(OP_SUB_W, 5'd9, 5'd2, 5'd1));
        prog.push_back(asm_3r(OP_SLT, 5'd10, 5'd2, 5'd1));
        prog.push_back(asm_3r(OP_SLTU, 5'd11, 5'd2, 5'd1));
        prog.push_back(asm_3r(OP_SLT, 5'd12, 5'd3, 5'd1));
        prog.push_back(asm_3r(OP_AND, 5'd13, 5'd4, 5'd5));
        prog.push_back(asm_3r(OP_OR, 5'd14, 5'd4, 5'd6));
        prog.push_back(asm_3r(OP_NOR, 5'd15, 5'd4, 5'd2));
        prog.push_back(asm_3r(OP_XOR, 5'd16, 5'd4, 5'd3));
        // Shift immediates
        prog.push_back(asm_3r(OP_SLLI_W, 5'd17, 5'd4, 5'd4));
        prog.push_back(asm_3r(OP_SRLI_W, 5'd18, 5'd3, 5'd31));
        prog.push_back(asm_3r(OP_SRAI_W, 5'd19, 5'd3, 5'd4));
        prog.push_back(asm_3r(OP_SRAI_W, 5'd20, 5'd2, 5'd1));
        // Dependent chain where the last one takes one operand from each stage
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd21, 5'd1, 12'h001));
        prog.push_back(asm_3r(OP_ADD_W, 5'd21, 5'd21, 5'd21));
        prog.push_back(asm_3r(OP_XOR, 5'd21, 5'd21, 5'd4));
        prog.push_back(asm_3r(OP_SUB_W, 5'd22, 5'd21, 5'd5));
        prog.push_back(asm_3r(OP_ADD_W, 5'd23, 5'd22, 5'd21));
        // Stores, loads and load-use
        prog.push_back(asm_ri12(OP_ST_W, 5'd4, 5'd7, 12'h000));
        prog.push_back(asm_ri12(OP_ST_W, 5'd3, 5'd7, 12'h004));
        prog.push_back(asm_ri12(OP_LD_W, 5'd24, 5'd7, 12'h000));
        prog.push_back(asm_3r(OP_ADD_W, 5'd25, 5'd24, 5'd1));
        prog.push_back(asm_ri12(OP_LD_W, 5'd26, 5'd7, 12'h004));
        prog.push_back(asm_ri12(OP_ST_W, 5'd26, 5'd7, 12'h008));
        prog.push_back(asm_ri12(OP_LD_W, 5'd27, 5'd7, 12'h008));
        prog.push_back(asm_ri12(OP_LD_W, 5'd28, 5'd7, 12'hfc0));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd29, 5'd28, 12'h001));
        // Writes to r0 must vanish
        prog.push_back(asm_3r(OP_ADD_W, 5'd0, 5'd1, 5'd2));
        prog.push_back(asm_ri12(OP_ADDI_W, 5'd0, 5'd0, 12'h005));
        prog.push_back(asm_ri12(OP_LD_W, 5'd0, 5'd7, 12'h000));
        prog.push_back(asm_3r(OP_ADD_W, 5'd30, 5'd0, 5'd1));
        for (int n = 0; n < 200; n++) begin
            add_random_inst();
        end
    endtask

    // Drive on the falling edge where allowin holds until the next rise
    task automatic feed_program();
        int    idx;
        word_t last_inst;
        logic  last_was_ld;
        logic  expect_stall;
        idx          = 0;
        last_inst    = WORD_ZERO;
        last_was_ld  = 1'b0;
        expect_stall = 1'b0;
        while (idx < prog.size()) begin
            @(negedge clk);
            if (expect_stall) begin
                check_bit("load-use stall", 1'b0, inst_allowin);
                stall_count++;
                expect_stall = 1'b0;
            end
            inst_valid = 1'b1;
            inst       = prog[idx];
            if (inst_allowin) begin
                expect_stall = last_was_ld && reads_reg(prog[idx], last_inst[4:0]);
                last_was_ld  = prog[idx][31:22] == OP_LD_W && prog[idx][4:0] != REG_ZERO;
                last_inst    = prog[idx];
                run_model(prog[idx]);
                idx++;
            end
        end
        @(negedge clk);
        if (expect_stall) begin
            check_bit("load-use stall", 1'b0, inst_allowin);
            stall_count++;
        end
        inst_valid = 1'b0;
    endtask

    ////////////////////////////////////////
    // Data SRAM model
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (data_sram_en) begin
            if (data_sram_we == 4'hf) begin
                sram[data_sram_addr[9:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= sram[data_sram_addr[9:2]];
        end
    end

    ////////////////////////////////////////
    // Output checks
    ////////////////////////////////////////
    always @(negedge clk) begin : wb_check
        reg_idx_t waddr;
        word_t    wdata;
        if (resetn && wb_valid === 1'b1) begin
            assert (exp_waddr.size() > 0) else begin
                $display("Writeback to r%0d arrived with no write expected", wb_rf_waddr);
                fail_run();
            end
            assert (wb_rf_waddr != REG_ZERO) else begin
                $display("Writeback to r0 appeared at the register file port");
                fail_run();
            end
            waddr = exp_waddr.pop_front();
            wdata = exp_wdata.pop_front();
            check_word("writeback address", {27'd0, waddr}, {27'd0, wb_rf_waddr});
            check_word($sformatf("writeback r%0d", waddr), wdata, wb_rf_wdata);
        end
    end

    always @(negedge clk) begin : sram_check
        logic  is_store;
        word_t addr;
        word_t data;
        if (resetn && data_sram_en === 1'b1) begin
            assert (acc_store.size() > 0) else begin
                $display("Data SRAM request at %h with no access expected", data_sram_addr);
                fail_run();
            end
            is_store = acc_store.pop_front();
            addr     = acc_addr.pop_front();
            data     = acc_data.pop_front();
            check_word("data SRAM address", addr, data_sram_addr);
            if (is_store) begin
                check_word("st.w write enable", 32'hf, {28'd0, data_sram_we});
                check_word("st.w write data", data, data_sram_wdata);
            end else begin
                check_word("ld.w write enable", 32'h0, {28'd0, data_sram_we});
            end
        end else if (resetn) begin
            check_word("idle write enable", 32'h0, {28'd0, data_sram_we});
        end
    end

    // Cycle limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            fail_run();
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        resetn          = 1'b0;
        inst_valid      = 1'b0;
        inst            = WORD_ZERO;
        data_sram_rdata = WORD_ZERO;
        for (int i = 0; i < 256; i++) begin
            sram[i]    = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = WORD_ZERO;
        end
        build_program();
        cycle_limit = 8 * prog.size() + 16;

        repeat (16) @(negedge clk);
        resetn = 1'b1;
        check_bit("reset wb_valid", 1'b0, wb_valid);
        check_bit("reset data_sram_en", 1'b0, data_sram_en);
        check_word("reset data_sram_we", 32'h0, {28'd0, data_sram_we});
        check_bit("reset inst_allowin", 1'b1, inst_allowin);

        feed_program();
        while (exp_waddr.size() != 0 || acc_store.size() != 0) begin
            @(negedge clk);
        end
        // A few idle cycles catch stray writebacks
        repeat (4) @(negedge clk);
        if (stall_count > 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("No load-use stall was reached by the program");
            fail_run();
        end
    end

endmodule

`default_nettype wire

// File: core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    // Instruction input
    input  logic        inst_valid,
    input  word_t       inst,
    output logic        inst_allowin,
    // Data SRAM
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output word_t       data_sram_addr,
    output word_t       data_sram_wdata,
    input  word_t       data_sram_rdata,
    // Writeback
    output logic        wb_valid,
    output reg_idx_t    wb_rf_waddr,
    output word_t       wb_rf_wdata
);

    reg_idx_t rf_raddr1, rf_raddr2;
    word_t    rf_rdata1, rf_rdata2;

    id_ex_if  u_id_ex ();
    ex_mem_if u_ex_mem ();
    fwd_if    u_ex_fwd ();
    fwd_if    u_mem_fwd ();

    id_stage u_id_stage (
        .clk(clk), .resetn(resetn),
        .inst_valid(inst_valid), .inst(inst), .inst_allowin(inst_allowin),
        .id_ex(u_id_ex.id), .ex_fwd(u_ex_fwd.listener), .mem_fwd(u_mem_fwd.listener),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2)
    );

    ex_stage u_ex_stage (
        .clk(clk), .resetn(resetn),
        .id_ex(u_id_ex.ex), .ex_mem(u_ex_mem.ex), .ex_fwd(u_ex_fwd.source),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk(clk), .resetn(resetn),
        .ex_mem(u_ex_mem.mem), .data_sram_rdata(data_sram_rdata),
        .mem_fwd(u_mem_fwd.source),
        .rf_we(wb_valid), .rf_waddr(wb_rf_waddr), .rf_wdata(wb_rf_wdata)
    );

    regfile u_regfile (
        .clk(clk),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(wb_valid), .waddr(wb_rf_waddr), .wdata(wb_rf_wdata)
    );

endmodule

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    ex_mem_if.mem       ex_mem,
    input  word_t       data_sram_rdata,
    fwd_if.source       mem_fwd,
    output logic        rf_we,
    output reg_idx_t    rf_waddr,
    output word_t       rf_wdata
);

    logic     mem_valid;
    logic     mem_ready_go;
    logic     mem_rf_we;
    reg_idx_t mem_rf_waddr;
    word_t    mem_alu_result;
    logic     mem_res_from_mem;

    // Last stage, nothing downstream to wait for
    assign mem_ready_go   = 1'b1;
    assign ex_mem.allowin = ~mem_valid | mem_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (ex_mem.allowin) begin
            mem_valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem.valid && ex_mem.allowin) begin
            mem_rf_we        <= ex_mem.rf_we;
            mem_rf_waddr     <= ex_mem.rf_waddr;
            mem_alu_result   <= ex_mem.alu_result;
            mem_res_from_mem <= ex_mem.res_from_mem;
        end
    end

    // SRAM read data arrives the cycle after the request
    assign rf_we    = mem_valid & mem_rf_we;
    assign rf_waddr = mem_rf_waddr;
    assign rf_wdata = mem_res_from_mem ? data_sram_rdata : mem_alu_result;

    assign mem_fwd.valid_we = rf_we;
    assign mem_fwd.is_load  = 1'b0;
    assign mem_fwd.waddr    = rf_waddr;
    assign mem_fwd.wdata    = rf_wdata;

endmodule

`default_nettype wire

// File: ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    id_ex_if.ex         id_ex,
    ex_mem_if.ex        ex_mem,
    fwd_if.source       ex_fwd,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output word_t       data_sram_addr,
    output word_t       data_sram_wdata
);

    logic     ex_valid;
    logic     ex_ready_go;
    logic     ex_go;
    alu_op_t  ex_alu_op;
    word_t    ex_alu_src1;
    word_t    ex_alu_src2;
    logic     ex_rf_we;
    reg_idx_t ex_rf_waddr;
    logic     ex_mem_we;
    word_t    ex_rkd_value;
    logic     ex_res_from_mem;
    word_t    ex_alu_result;

    ////////////////////////////////////////
    // Stage control
    ////////////////////////////////////////
    assign ex_ready_go   = 1'b1;
    assign id_ex.allowin = ~ex_valid | ex_ready_go & ex_mem.allowin;
    assign ex_mem.valid  = ex_valid & ex_ready_go;
    // Leaving for memory this cycle
    assign ex_go         = ex_mem.valid & ex_mem.allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (id_ex.allowin) begin
            ex_valid <= id_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_ex.valid && id_ex.allowin) begin
            ex_alu_op       <= id_ex.alu_op;
            ex_alu_src1     <= id_ex.alu_src1;
            ex_alu_src2     <= id_ex.alu_src2;
            ex_rf_we        <= id_ex.rf_we;
            ex_rf_waddr     <= id_ex.rf_waddr;
            ex_mem_we       <= id_ex.mem_we;
            ex_rkd_value    <= id_ex.rkd_value;
            ex_res_from_mem <= id_ex.res_from_mem;
        end
    end

    alu u_alu (
        .alu_op     (ex_alu_op),
        .alu_src1   (ex_alu_src1),
        .alu_src2   (ex_alu_src2),
        .alu_result (ex_alu_result)
    );

    assign ex_mem.rf_we        = ex_rf_we;
    assign ex_mem.rf_waddr     = ex_rf_waddr;
    assign ex_mem.alu_result   = ex_alu_result;
    assign ex_mem.res_from_mem = ex_res_from_mem;

    // Bypass source, gated by valid
    assign ex_fwd.valid_we = ex_valid & ex_rf_we;
    assign ex_fwd.is_load  = ex_valid & ex_res_from_mem;
    assign ex_fwd.waddr    = ex_rf_waddr;
    assign ex_fwd.wdata    = ex_alu_result;

    ////////////////////////////////////////
    // Data SRAM request
    ////////////////////////////////////////
    assign data_sram_en    = ex_go & (ex_res_from_mem | ex_mem_we);
    assign data_sram_we    = {4{ex_go & ex_mem_we}};
    assign data_sram_addr  = ex_alu_result;
    assign data_sram_wdata = ex_rkd_value;

endmodule

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import cpu_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  logic          inst_valid,
    input  word_t         inst,
    output logic          inst_allowin,
    id_ex_if.id           id_ex,
    fwd_if.listener       ex_fwd,
    fwd_if.listener       mem_fwd,
    output reg_idx_t      rf_raddr1,
    output reg_idx_t      rf_raddr2,
    input  word_t         rf_rdata1,
    input  word_t         rf_rdata2
);

    logic     id_valid;
    word_t    id_inst;
    logic     id_ready_go;
    reg_idx_t rd, rj, rk;
    logic     inst_add, inst_sub, inst_slt, inst_sltu, inst_and, inst_or;
    logic     inst_nor, inst_xor, inst_slli, inst_srli, inst_srai;
    logic     inst_addi, inst_lu12i, inst_ld, inst_st;
    logic     inst_rr, uses_rj, uses_rkd, gr_we;
    logic     ex_hit1, ex_hit2, mem_hit1, mem_hit2, load_use;
    word_t    rj_value, rkd_value, imm;

    ////////////////////////////////////////
    // Stage control
    ////////////////////////////////////////
    assign id_ready_go  = ~load_use;
    assign inst_allowin = ~id_valid | id_ready_go & id_ex.allowin;
    assign id_ex.valid  = id_valid & id_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (inst_allowin) begin
            id_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_allowin) begin
            id_inst <= inst;
        end
    end

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    assign rd = id_inst[4:0];
    assign rj = id_inst[9:5];
    assign rk = id_inst[14:10];

    assign inst_add   = id_inst[31:15] == OP_ADD_W;
    assign inst_sub   = id_inst[31:15] == OP_SUB_W;
    assign inst_slt   = id_inst[31:15] == OP_SLT;
    assign inst_sltu  = id_inst[31:15] == OP_SLTU;
    assign inst_nor   = id_inst[31:15] == OP_NOR;
    assign inst_and   = id_inst[31:15] == OP_AND;
    assign inst_or    = id_inst[31:15] == OP_OR;
    assign inst_xor   = id_inst[31:15] == OP_XOR;
    assign inst_slli  = id_inst[31:15] == OP_SLLI_W;
    assign inst_srli  = id_inst[31:15] == OP_SRLI_W;
    assign inst_srai  = id_inst[31:15] == OP_SRAI_W;
    assign inst_addi  = id_inst[31:22] == OP_ADDI_W;
    assign inst_ld    = id_inst[31:22] == OP_LD_W;
    assign inst_st    = id_inst[31:22] == OP_ST_W;
    assign inst_lu12i = id_inst[31:25] == OP_LU12I_W;

    assign inst_rr = inst_add | inst_sub | inst_slt | inst_sltu | inst_and | inst_or
                   | inst_nor | inst_xor;

    always_comb begin
        id_ex.alu_op           = '0;
        id_ex.alu_op[ALU_ADD]  = inst_add | inst_addi | inst_ld | inst_st;
        id_ex.alu_op[ALU_SUB]  = inst_sub;
        id_ex.alu_op[ALU_SLT]  = inst_slt;
        id_ex.alu_op[ALU_SLTU] = inst_sltu;
        id_ex.alu_op[ALU_AND]  = inst_and;
        id_ex.alu_op[ALU_NOR]  = inst_nor;
        id_ex.alu_op[ALU_OR]   = inst_or;
        id_ex.alu_op[ALU_XOR]  = inst_xor;
        id_ex.alu_op[ALU_SLL]  = inst_slli;
        id_ex.alu_op[ALU_SRL]  = inst_srli;
        id_ex.alu_op[ALU_SRA]  = inst_srai;
        id_ex.alu_op[ALU_LUI]  = inst_lu12i;
    end

    // si12, ui5 or si20 depending on the format
    always_comb begin
        if (inst_lu12i) begin
            imm = {id_inst[24:5], 12'h000};
        end else if (inst_slli | inst_srli | inst_srai) begin
            imm = {27'd0, id_inst[14:10]};
        end else begin
            imm = {{20{id_inst[21]}}, id_inst[21:10]};
        end
    end

    assign uses_rj  = ~inst_lu12i;
    assign uses_rkd = inst_rr | inst_st;
    assign gr_we    = (inst_rr | inst_slli | inst_srli | inst_srai | inst_addi
                    | inst_lu12i | inst_ld);

    ////////////////////////////////////////
    // Operands and bypass
    ////////////////////////////////////////
    assign rf_raddr1 = rj;
    assign rf_raddr2 = inst_st ? rd : rk;

    assign ex_hit1  = ex_fwd.valid_we  && ex_fwd.waddr  == rf_raddr1;
    assign ex_hit2  = ex_fwd.valid_we  && ex_fwd.waddr  == rf_raddr2;
    assign mem_hit1 = mem_fwd.valid_we && mem_fwd.waddr == rf_raddr1;
    assign mem_hit2 = mem_fwd.valid_we && mem_fwd.waddr == rf_raddr2;

    // Execute wins over memory
    assign rj_value  = ex_hit1 ? ex_fwd.wdata : mem_hit1 ? mem_fwd.wdata : rf_rdata1;
    assign rkd_value = ex_hit2 ? ex_fwd.wdata : mem_hit2 ? mem_fwd.wdata : rf_rdata2;

    // Load data is not ready until the memory stage
    assign load_use = id_valid & ex_fwd.is_load & (ex_hit1 & uses_rj | ex_hit2 & uses_rkd);

    assign id_ex.alu_src1     = rj_value;
    assign id_ex.alu_src2     = inst_rr ? rkd_value : imm;
    assign id_ex.rf_we        = gr_we & (rd != REG_ZERO);
    assign id_ex.rf_waddr     = rd;
    assign id_ex.mem_we       = inst_st;
    assign id_ex.rkd_value    = rkd_value;
    assign id_ex.res_from_mem = inst_ld;

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result
);

    logic  sub_mode;
    word_t adder_b;
    word_t adder_sum;
    logic  adder_cout;
    word_t slt_result;
    word_t sltu_result;
    word_t sll_result;
    word_t srl_result;
    word_t sra_result;

    ////////////////////////////////////////
    // Shared adder
    ////////////////////////////////////////
    // Subtract and both compares use src1 - src2
    assign sub_mode = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
    assign adder_b  = sub_mode ? ~alu_src2 : alu_src2;
    assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, sub_mode};

    // Signed less-than from operand signs and difference sign
    assign slt_result  = {31'd0, (alu_src1[31] & ~alu_src2[31])
                               | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31])};
    assign sltu_result = {31'd0, ~adder_cout};

    // Shifts use the low five bits only
    assign sll_result = alu_src1 << alu_src2[4:0];
    assign srl_result = alu_src1 >> alu_src2[4:0];
    assign sra_result = $signed(alu_src1) >>> alu_src2[4:0];

    ////////////////////////////////////////
    // One-hot result select
    ////////////////////////////////////////
    assign alu_result = ({32{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & adder_sum)
                      | ({32{alu_op[ALU_SLT]}}  & slt_result)
                      | ({32{alu_op[ALU_SLTU]}} & sltu_result)
                      | ({32{alu_op[ALU_AND]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[ALU_NOR]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_OR]}}   & (alu_src1 | alu_src2))
                      | ({32{alu_op[ALU_XOR]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[ALU_SLL]}}  & sll_result)
                      | ({32{alu_op[ALU_SRL]}}  & srl_result)
                      | ({32{alu_op[ALU_SRA]}}  & sra_result)
                      | ({32{alu_op[ALU_LUI]}}  & alu_src2);

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    // r0 is not stored
    word_t rf [31:1];

    always_ff @(posedge clk) begin
        if (we && waddr != REG_ZERO) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == REG_ZERO) ? WORD_ZERO : rf[raddr1];
    assign rdata2 = (raddr2 == REG_ZERO) ? WORD_ZERO : rf[raddr2];

endmodule

`default_nettype wire

// File: pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded operation from decode to execute
interface id_ex_if import cpu_pkg::*; ();
    logic     valid;
    logic     allowin;
    alu_op_t  alu_op;
    word_t    alu_src1;
    word_t    alu_src2;
    logic     rf_we;
    reg_idx_t rf_waddr;
    logic     mem_we;
    word_t    rkd_value;
    logic     res_from_mem;

    modport id (output valid, alu_op, alu_src1, alu_src2, rf_we, rf_waddr,
                       mem_we, rkd_value, res_from_mem,
                input  allowin);
    modport ex (input  valid, alu_op, alu_src1, alu_src2, rf_we, rf_waddr,
                       mem_we, rkd_value, res_from_mem,
                output allowin);
endinterface

// Executed operation from execute to memory
interface ex_mem_if import cpu_pkg::*; ();
    logic     valid;
    logic     allowin;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    alu_result;
    logic     res_from_mem;

    modport ex  (output valid, rf_we, rf_waddr, alu_result, res_from_mem, input allowin);
    modport mem (input valid, rf_we, rf_waddr, alu_result, res_from_mem, output allowin);
endinterface

// Bypass info from a later stage back to decode
interface fwd_if import cpu_pkg::*; ();
    logic     valid_we;
    logic     is_load;
    reg_idx_t waddr;
    word_t    wdata;

    modport source   (output valid_we, is_load, waddr, wdata);
    modport listener (input  valid_we, is_load, waddr, wdata);
endinterface

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] alu_op_t;

    // Bit positions inside alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    ////////////////////////////////////////
    // Opcode fields
    ////////////////////////////////////////

    // inst[31:15], three-register and shift-immediate forms
    localparam logic [16:0] OP_ADD_W  = 17'h00020;
    localparam logic [16:0] OP_SUB_W  = 17'h00022;
    localparam logic [16:0] OP_SLT    = 17'h00024;
    localparam logic [16:0] OP_SLTU   = 17'h00025;
    localparam logic [16:0] OP_NOR    = 17'h00028;
    localparam logic [16:0] OP_AND    = 17'h00029;
    localparam logic [16:0] OP_OR     = 17'h0002a;
    localparam logic [16:0] OP_XOR    = 17'h0002b;
    localparam logic [16:0] OP_SLLI_W = 17'h00081;
    localparam logic [16:0] OP_SRLI_W = 17'h00089;
    localparam logic [16:0] OP_SRAI_W = 17'h00091;

    // inst[31:22], 12-bit immediate forms
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;

    // inst[31:25]
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;

    // Reset and zero values
    localparam word_t    WORD_ZERO = 32'h0000_0000;
    localparam reg_idx_t REG_ZERO  = 5'd0;

endpackage

`default_nettype wire
